//--- run_sim.sh
#!/bin/sh
# build and run the control channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f src.f \
	--top-module tb_ctrl_channel \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0

//--- src.f
src/ctrl_channel_pkg.sv
src/spi_bus_if.sv
src/spi_sampler.sv
src/bit_counter.sv
src/ctrl_fsm.sv
src/reg_bank.sv
src/ctrl_channel.sv
verif/tb_clk_gen.sv
verif/ctrl_channel_properties.sv
verif/tb_ctrl_channel.sv

//--- src/bit_counter.sv
// bit counter for the current frame field with last bit flag
`timescale 1ns/1ns
module bit_counter import ctrl_channel_pkg::*; (
	input  logic i_clk_osc_bufg,
	input  logic i_arst_n,
	input  logic i_clear,
	input  logic i_step,
	input  logic i_long,
	output logic o_last
);

	logic [BIT_CNT_WD-1:0] cnt;
	logic [BIT_CNT_WD-1:0] cnt_end;

	// opcode and address fields share the short length
	assign cnt_end = i_long ? BIT_CNT_WD'(DATA_WD - 1) : BIT_CNT_WD'(OPCODE_WD - 1);

	// high while the current bit is the final one of the field
	assign o_last = (cnt == cnt_end);

	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt <= '0;
		end else if (i_clear) begin
			cnt <= '0;
		end else if (i_step) begin
			// wrap so the next field starts at zero
			if (o_last) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

//--- src/ctrl_channel.sv
// control channel top level with SPI sampler, bit counter, frame FSM and register bank
`timescale 1ns/1ns
module ctrl_channel import ctrl_channel_pkg::*; (
	input  logic                   i_clk_osc_bufg,
	input  logic                   i_arst_n,
	// spi pins
	input  logic                   i_spi_clk,
	input  logic                   i_spi_cs_n,
	input  logic                   i_spi_mosi,
	output logic                   o_spi_miso_data,
	output logic                   o_spi_miso_data_en,
	// system status
	input  logic                   i_fval,
	input  logic                   i_sensor_reset_done,
	input  logic                   i_ddr_init_done,
	input  logic                   i_ddr_error,
	// configuration
	output logic                   o_stream_enable,
	output logic                   o_acquisition_start,
	output logic                   o_trigger_mode,
	output logic                   o_reset_sensor,
	output logic                   o_trigger_soft,
	output logic [TRIG_SRC_WD-1:0] o_trigger_source,
	output logic [DATA_WD-1:0]     o_trigger_delay,
	output logic [LED_WD-1:0]      o_led_ctrl,
	output logic [DATA_WD-1:0]     o_pixel_format
);

	logic               cnt_clear;
	logic               cnt_step;
	logic               cnt_long;
	logic               cnt_last;
	logic               wr_en;
	logic [ADDR_WD-1:0] wr_addr;
	logic [DATA_WD-1:0] wr_data;
	logic [ADDR_WD-1:0] rd_addr;
	logic [DATA_WD-1:0] rd_data;

	spi_bus_if spi_bus_inst ();

	// ------------------------------------------------------------------
	// spi front end
	// ------------------------------------------------------------------
	spi_sampler spi_sampler_inst (
		.i_clk_osc_bufg		(i_clk_osc_bufg		),
		.i_arst_n			(i_arst_n			),
		.i_spi_clk			(i_spi_clk			),
		.i_spi_cs_n			(i_spi_cs_n			),
		.i_spi_mosi			(i_spi_mosi			),
		.o_spi_miso_data	(o_spi_miso_data	),
		.o_spi_miso_data_en	(o_spi_miso_data_en	),
		.bus				(spi_bus_inst.sampler	)
	);

	bit_counter bit_counter_inst (
		.i_clk_osc_bufg		(i_clk_osc_bufg		),
		.i_arst_n			(i_arst_n			),
		.i_clear			(cnt_clear			),
		.i_step				(cnt_step			),
		.i_long				(cnt_long			),
		.o_last				(cnt_last			)
	);

	// ------------------------------------------------------------------
	// frame decode and registers
	// ------------------------------------------------------------------
	ctrl_fsm ctrl_fsm_inst (
		.i_clk_osc_bufg		(i_clk_osc_bufg		),
		.i_arst_n			(i_arst_n			),
		.bus				(spi_bus_inst.fsm	),
		.o_cnt_clear		(cnt_clear			),
		.o_cnt_step			(cnt_step			),
		.o_cnt_long			(cnt_long			),
		.i_cnt_last			(cnt_last			),
		.o_wr_en			(wr_en				),
		.o_wr_addr			(wr_addr			),
		.o_wr_data			(wr_data			),
		.o_rd_addr			(rd_addr			),
		.i_rd_data			(rd_data			)
	);

	reg_bank reg_bank_inst (
		.i_clk_osc_bufg		(i_clk_osc_bufg		),
		.i_arst_n			(i_arst_n			),
		.i_wr_en			(wr_en				),
		.i_wr_addr			(wr_addr			),
		.i_rd_addr			(rd_addr			),
		.i_wr_data			(wr_data			),
		.o_rd_data			(rd_data			),
		.i_fval				(i_fval				),
		.i_sensor_reset_done	(i_sensor_reset_done	),
		.i_ddr_init_done	(i_ddr_init_done	),
		.i_ddr_error		(i_ddr_error		),
		.o_stream_enable	(o_stream_enable	),
		.o_acquisition_start	(o_acquisition_start	),
		.o_trigger_mode		(o_trigger_mode		),
		.o_reset_sensor		(o_reset_sensor		),
		.o_trigger_soft		(o_trigger_soft		),
		.o_trigger_source	(o_trigger_source	),
		.o_trigger_delay	(o_trigger_delay	),
		.o_led_ctrl			(o_led_ctrl			),
		.o_pixel_format		(o_pixel_format		)
	);

endmodule

//--- src/ctrl_channel_pkg.sv
// field widths, opcode and state enums, register map and reset values of the control channel
package ctrl_channel_pkg;

	// ------------------------------------------------------------------
	// frame fields
	// ------------------------------------------------------------------
	localparam int OPCODE_WD   = 8;
	localparam int ADDR_WD     = 8;
	localparam int DATA_WD     = 16;
	localparam int BIT_CNT_WD  = 4;

	// register field widths
	localparam int LED_WD      = 5;
	localparam int TRIG_SRC_WD = 4;
	localparam int CTRL_WD     = 4;
	localparam int STATUS_WD   = 4;

	typedef enum logic [OPCODE_WD-1:0] {
		OP_WRITE = 8'h01,
		OP_READ  = 8'h02
	} op_e;

	typedef enum logic [2:0] {
		S_IDLE   = 3'd0,
		S_OPCODE = 3'd1,
		S_ADDR   = 3'd2,
		S_WDATA  = 3'd3,
		S_RDATA  = 3'd4,
		S_IGNORE = 3'd5
	} fsm_state_e;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------
	localparam logic [ADDR_WD-1:0] ADDR_CTRL       = 8'h00;
	localparam logic [ADDR_WD-1:0] ADDR_TRIG_SRC   = 8'h01;
	localparam logic [ADDR_WD-1:0] ADDR_TRIG_DELAY = 8'h02;
	localparam logic [ADDR_WD-1:0] ADDR_LED        = 8'h03;
	localparam logic [ADDR_WD-1:0] ADDR_PIXEL_FMT  = 8'h04;
	localparam logic [ADDR_WD-1:0] ADDR_TRIG_SOFT  = 8'h05;
	// read only
	localparam logic [ADDR_WD-1:0] ADDR_STATUS     = 8'h10;
	localparam logic [ADDR_WD-1:0] ADDR_VERSION    = 8'h11;

	// control register bits
	localparam int CTRL_STREAM_EN  = 0;
	localparam int CTRL_ACQ_START  = 1;
	localparam int CTRL_TRIG_MODE  = 2;
	localparam int CTRL_SENSOR_RST = 3;

	// status word bits
	localparam int STAT_FVAL            = 0;
	localparam int STAT_DDR_ERROR       = 1;
	localparam int STAT_DDR_INIT_DONE   = 2;
	localparam int STAT_SENSOR_RST_DONE = 3;

	localparam logic [DATA_WD-1:0] PIXEL_FMT_INIT = 16'h0108;
	localparam logic [DATA_WD-1:0] VERSION_VALUE  = 16'h2015;

endpackage

//--- src/ctrl_fsm.sv
// frame FSM: opcode and address decode, register write strobe, read data load
`timescale 1ns/1ns
module ctrl_fsm import ctrl_channel_pkg::*; (
	input  logic               i_clk_osc_bufg,
	input  logic               i_arst_n,
	spi_bus_if.fsm             bus,
	output logic               o_cnt_clear,
	output logic               o_cnt_step,
	output logic               o_cnt_long,
	input  logic               i_cnt_last,
	output logic               o_wr_en,
	output logic [ADDR_WD-1:0] o_wr_addr,
	output logic [DATA_WD-1:0] o_wr_data,
	output logic [ADDR_WD-1:0] o_rd_addr,
	input  logic [DATA_WD-1:0] i_rd_data
);

	fsm_state_e         state;
	fsm_state_e         state_nxt;
	op_e                opcode;
	logic [ADDR_WD-1:0] addr;
	logic [DATA_WD-1:0] wdata;
	logic               field_done;

	assign field_done = bus.rx_strobe & i_cnt_last;

	// ------------------------------------------------------------------
	// state transitions
	// ------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (bus.frame_start) begin
					state_nxt = S_OPCODE;
				end
			end
			S_OPCODE: begin
				if (field_done) begin
					if (bus.rx_byte == OP_WRITE || bus.rx_byte == OP_READ) begin
						state_nxt = S_ADDR;
					end else begin
						state_nxt = S_IGNORE;
					end
				end
			end
			S_ADDR: begin
				if (field_done) begin
					state_nxt = (opcode == OP_READ) ? S_RDATA : S_WDATA;
				end
			end
			S_WDATA, S_RDATA: begin
				// any trailing bits are dropped
				if (field_done) begin
					state_nxt = S_IGNORE;
				end
			end
			default: begin
				state_nxt = state;
			end
		endcase
		// chip select high ends the frame from any state
		if (!bus.cs_active) begin
			state_nxt = S_IDLE;
		end
	end

	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state       <= S_IDLE;
			bus.tx_load <= 1'b0;
		end else begin
			state       <= state_nxt;
			bus.tx_load <= (state == S_ADDR) && field_done && (opcode == OP_READ);
		end
	end

	// ------------------------------------------------------------------
	// field capture
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg) begin
		if (state == S_OPCODE && field_done) begin
			opcode <= op_e'(bus.rx_byte);
		end
		if (state == S_ADDR && field_done) begin
			addr <= bus.rx_byte;
		end
		if (state == S_WDATA && bus.rx_strobe) begin
			wdata <= {wdata[DATA_WD-2:0], bus.rx_bit};
		end
	end

	// bit counter control
	assign o_cnt_clear = bus.frame_start;
	assign o_cnt_step  = bus.rx_strobe && (state != S_IDLE) && (state != S_IGNORE);
	assign o_cnt_long  = (state == S_WDATA) || (state == S_RDATA);

	// write commits on the clock edge after the last data strobe
	assign o_wr_en   = (state == S_WDATA) && field_done;
	assign o_wr_addr = addr;
	assign o_wr_data = {wdata[DATA_WD-2:0], bus.rx_bit};

	// read path
	assign o_rd_addr     = addr;
	assign bus.tx_word   = i_rd_data;
	assign bus.tx_active = (state == S_RDATA);

endmodule

//--- src/reg_bank.sv
// configuration registers, soft trigger pulse, status word and read multiplexer
`timescale 1ns/1ns
module reg_bank import ctrl_channel_pkg::*; (
	input  logic                   i_clk_osc_bufg,
	input  logic                   i_arst_n,
	input  logic                   i_wr_en,
	input  logic [ADDR_WD-1:0]     i_wr_addr,
	input  logic [ADDR_WD-1:0]     i_rd_addr,
	input  logic [DATA_WD-1:0]     i_wr_data,
	output logic [DATA_WD-1:0]     o_rd_data,
	input  logic                   i_fval,
	input  logic                   i_sensor_reset_done,
	input  logic                   i_ddr_init_done,
	input  logic                   i_ddr_error,
	output logic                   o_stream_enable,
	output logic                   o_acquisition_start,
	output logic                   o_trigger_mode,
	output logic                   o_reset_sensor,
	output logic                   o_trigger_soft,
	output logic [TRIG_SRC_WD-1:0] o_trigger_source,
	output logic [DATA_WD-1:0]     o_trigger_delay,
	output logic [LED_WD-1:0]      o_led_ctrl,
	output logic [DATA_WD-1:0]     o_pixel_format
);

	logic [CTRL_WD-1:0]     ctrl_reg;
	logic [TRIG_SRC_WD-1:0] trig_src_reg;
	logic [DATA_WD-1:0]     trig_delay_reg;
	logic [LED_WD-1:0]      led_reg;
	logic [DATA_WD-1:0]     pixel_fmt_reg;
	logic                   trig_soft;
	logic [STATUS_WD-1:0]   status_raw;
	logic [STATUS_WD-1:0]   status_meta;
	logic [STATUS_WD-1:0]   status_sync;

	// ------------------------------------------------------------------
	// writable registers
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ctrl_reg       <= '0;
			trig_src_reg   <= '0;
			trig_delay_reg <= '0;
			led_reg        <= '0;
			pixel_fmt_reg  <= PIXEL_FMT_INIT;
			trig_soft      <= 1'b0;
		end else begin
			// one cycle pulse per write, no storage behind it
			trig_soft <= i_wr_en && (i_wr_addr == ADDR_TRIG_SOFT);
			if (i_wr_en) begin
				case (i_wr_addr)
					ADDR_CTRL:       ctrl_reg       <= i_wr_data[CTRL_WD-1:0];
					ADDR_TRIG_SRC:   trig_src_reg   <= i_wr_data[TRIG_SRC_WD-1:0];
					ADDR_TRIG_DELAY: trig_delay_reg <= i_wr_data;
					ADDR_LED:        led_reg        <= i_wr_data[LED_WD-1:0];
					ADDR_PIXEL_FMT:  pixel_fmt_reg  <= i_wr_data;
					default: begin
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------
	// status inputs
	// ------------------------------------------------------------------
	always_comb begin
		status_raw                       = '0;
		status_raw[STAT_FVAL]            = i_fval;
		status_raw[STAT_DDR_ERROR]       = i_ddr_error;
		status_raw[STAT_DDR_INIT_DONE]   = i_ddr_init_done;
		status_raw[STAT_SENSOR_RST_DONE] = i_sensor_reset_done;
	end

	// system inputs are not in this clock domain
	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			status_meta <= '0;
			status_sync <= '0;
		end else begin
			status_meta <= status_raw;
			status_sync <= status_meta;
		end
	end

	// ------------------------------------------------------------------
	// read multiplexer
	// ------------------------------------------------------------------
	always_comb begin
		case (i_rd_addr)
			ADDR_CTRL:       o_rd_data = {{(DATA_WD-CTRL_WD){1'b0}}, ctrl_reg};
			ADDR_TRIG_SRC:   o_rd_data = {{(DATA_WD-TRIG_SRC_WD){1'b0}}, trig_src_reg};
			ADDR_TRIG_DELAY: o_rd_data = trig_delay_reg;
			ADDR_LED:        o_rd_data = {{(DATA_WD-LED_WD){1'b0}}, led_reg};
			ADDR_PIXEL_FMT:  o_rd_data = pixel_fmt_reg;
			ADDR_STATUS:     o_rd_data = {{(DATA_WD-STATUS_WD){1'b0}}, status_sync};
			ADDR_VERSION:    o_rd_data = VERSION_VALUE;
			// soft trigger and unmapped addresses
			default:         o_rd_data = '0;
		endcase
	end

	assign o_stream_enable     = ctrl_reg[CTRL_STREAM_EN];
	assign o_acquisition_start = ctrl_reg[CTRL_ACQ_START];
	assign o_trigger_mode      = ctrl_reg[CTRL_TRIG_MODE];
	assign o_reset_sensor      = ctrl_reg[CTRL_SENSOR_RST];
	assign o_trigger_soft      = trig_soft;
	assign o_trigger_source    = trig_src_reg;
	assign o_trigger_delay     = trig_delay_reg;
	assign o_led_ctrl          = led_reg;
	assign o_pixel_format      = pixel_fmt_reg;

endmodule

//--- src/spi_bus_if.sv
// sampled SPI events and transmit load signals between the pin sampler and the frame FSM
`timescale 1ns/1ns
interface spi_bus_if import ctrl_channel_pkg::*; ();

	// sampler side
	logic                 cs_active;
	logic                 frame_start;
	logic                 rx_strobe;
	logic                 rx_bit;
	logic [OPCODE_WD-1:0] rx_byte;

	// fsm side
	logic                 tx_load;
	logic [DATA_WD-1:0]   tx_word;
	logic                 tx_active;

	modport sampler (
		output cs_active, frame_start, rx_strobe, rx_bit, rx_byte,
		input  tx_load, tx_word, tx_active
	);

	modport fsm (
		input  cs_active, frame_start, rx_strobe, rx_bit, rx_byte,
		output tx_load, tx_word, tx_active
	);

endinterface

//--- src/spi_sampler.sv
// SPI pin synchronizers, clock and chip select edge detection, receive and transmit shifters
`timescale 1ns/1ns
module spi_sampler import ctrl_channel_pkg::*; (
	input  logic       i_clk_osc_bufg,
	input  logic       i_arst_n,
	input  logic       i_spi_clk,
	input  logic       i_spi_cs_n,
	input  logic       i_spi_mosi,
	output logic       o_spi_miso_data,
	output logic       o_spi_miso_data_en,
	spi_bus_if.sampler bus
);

	// [0] and [1] synchronize, [2] is the edge detect delay
	logic [2:0]           sclk_sync;
	logic [2:0]           cs_sync;
	logic [1:0]           mosi_sync;
	logic                 sclk_rise;
	logic                 sclk_fall;
	logic                 cs_fall;
	logic [OPCODE_WD-1:0] rx_shift;
	logic [DATA_WD-1:0]   tx_shift;
	logic                 tx_hold;

	// ------------------------------------------------------------------
	// pin synchronizers
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sclk_sync <= '0;
			cs_sync   <= '1;
			mosi_sync <= '0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], i_spi_clk};
			cs_sync   <= {cs_sync[1:0], i_spi_cs_n};
			mosi_sync <= {mosi_sync[0], i_spi_mosi};
		end
	end

	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
	assign cs_fall   = ~cs_sync[1] & cs_sync[2];

	assign bus.cs_active = ~cs_sync[1];

	// registered event pulses, 3 cycles after the pin edge
	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			bus.rx_strobe   <= 1'b0;
			bus.frame_start <= 1'b0;
		end else begin
			bus.rx_strobe   <= sclk_rise;
			bus.frame_start <= cs_fall;
		end
	end

	// ------------------------------------------------------------------
	// receive shifter, msb first
	// ------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg) begin
		if (sclk_rise) begin
			rx_shift   <= {rx_shift[OPCODE_WD-2:0], mosi_sync[1]};
			bus.rx_bit <= mosi_sync[1];
		end
	end

	assign bus.rx_byte = rx_shift;

	// ------------------------------------------------------------------
	// transmit shifter
	// ------------------------------------------------------------------
	// the load lands before the falling edge that closes the last address
	// bit, so that edge keeps the msb on the line
	always_ff @(posedge i_clk_osc_bufg or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tx_shift <= '0;
			tx_hold  <= 1'b0;
		end else if (bus.tx_load) begin
			tx_shift <= bus.tx_word;
			tx_hold  <= 1'b1;
		end else if (sclk_fall) begin
			if (tx_hold) begin
				tx_hold <= 1'b0;
			end else begin
				tx_shift <= {tx_shift[DATA_WD-2:0], 1'b0};
			end
		end
	end

	assign o_spi_miso_data    = tx_shift[DATA_WD-1];
	assign o_spi_miso_data_en = bus.tx_active;

endmodule

//--- verif/ctrl_channel_properties.sv
// bound assertions on soft trigger width, miso enable after chip select and write strobe state
`timescale 1ns/1ns
module ctrl_channel_properties import ctrl_channel_pkg::*; (
	input logic       i_clk_osc_bufg,
	input logic       i_arst_n,
	input logic       i_spi_cs_n,
	input logic       i_trigger_soft,
	input logic       i_spi_miso_data_en,
	input logic       i_wr_en,
	input fsm_state_e i_fsm_state
);

	// failed assertions, summed into the testbench error count
	int assert_fails = 0;

	// soft trigger is a single cycle pulse
	a_trig_single: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_arst_n)
		i_trigger_soft |=> !i_trigger_soft)
		else begin
			$error("soft trigger pulse lasted two cycles");
			assert_fails++;
		end

	// chip select high for three full cycles, miso must be released
	a_miso_release: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_arst_n)
		(i_spi_cs_n && $past(i_spi_cs_n, 1) && $past(i_spi_cs_n, 2) && $past(i_spi_cs_n, 3))
		|-> !i_spi_miso_data_en)
		else begin
			$error("miso enable still high after chip select went high");
			assert_fails++;
		end

	// one write per data field, the FSM leaves the write state after it
	a_wr_in_wdata: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_arst_n)
		i_wr_en |-> (i_fsm_state == S_WDATA) ##1 (i_fsm_state != S_WDATA))
		else begin
			$error("register write strobe outside the write data state");
			assert_fails++;
		end

endmodule

bind ctrl_channel ctrl_channel_properties ctrl_channel_properties_inst (
	.i_clk_osc_bufg		(i_clk_osc_bufg			),
	.i_arst_n			(i_arst_n				),
	.i_spi_cs_n			(i_spi_cs_n				),
	.i_trigger_soft		(o_trigger_soft			),
	.i_spi_miso_data_en	(o_spi_miso_data_en		),
	.i_wr_en			(wr_en					),
	.i_fsm_state		(ctrl_fsm_inst.state	)
);

//--- verif/tb_clk_gen.sv
// testbench clock and reset generator
`timescale 1ns/1ns
module tb_clk_gen (
	output logic o_clk,
	output logic o_arst_n
);

	localparam int HALF_PERIOD  = 10;
	localparam int RESET_CYCLES = 3;

	initial begin
		o_clk = 1'b0;
		forever #HALF_PERIOD o_clk = ~o_clk;
	end

	// release just after a rising edge
	initial begin
		o_arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#2 o_arst_n = 1'b1;
	end

endmodule

//--- verif/tb_ctrl_channel.sv
// directed testbench of the control channel: SPI master tasks, compare tasks, timeout
`timescale 1ns/1ns
module tb_ctrl_channel import ctrl_channel_pkg::*; ();

	localparam int HALF               = 4;
	localparam int DRIVE_DELAY        = 2;
	localparam int NUM_FRAMES         = 52;
	// 32 bit frame is 64 half periods, the rest covers chip select and gaps
	localparam int FRAME_HALF_PERIODS = 80;
	localparam int TIMEOUT_CYCLES     = NUM_FRAMES * FRAME_HALF_PERIODS * HALF + 200;
	localparam logic [31:0] LFSR_SEED = 32'h662b;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [7:0] UNKNOWN_OP    = 8'h5a;
	localparam logic [7:0] UNMAPPED_ADDR = 8'h3c;

	logic clk;
	logic arst_n;
	logic spi_clk;
	logic spi_cs_n;
	logic spi_mosi;
	logic miso;
	logic miso_en;
	logic fval;
	logic sensor_reset_done;
	logic ddr_init_done;
	logic ddr_error;
	logic stream_enable;
	logic acquisition_start;
	logic trigger_mode;
	logic reset_sensor;
	logic trigger_soft;
	logic [TRIG_SRC_WD-1:0] trigger_source;
	logic [DATA_WD-1:0]     trigger_delay;
	logic [LED_WD-1:0]      led_ctrl;
	logic [DATA_WD-1:0]     pixel_format;

	// expected register contents
	logic [3:0]  exp_ctrl;
	logic [15:0] exp_trig_src;
	logic [15:0] exp_trig_delay;
	logic [15:0] exp_led;
	logic [15:0] exp_pixel_fmt;

	int errors = 0;
	int cycles = 0;
	int trig_count = 0;
	int frames_done = 0;
	logic miso_quiet = 1'b0;
	logic [31:0] lfsr_state = LFSR_SEED;
	// miso enable seen at each sampled bit of the last frame
	logic [31:0] miso_en_bits;

	tb_clk_gen tb_clk_gen_inst (
		.o_clk		(clk	),
		.o_arst_n	(arst_n	)
	);

	ctrl_channel ctrl_channel_inst (
		.i_clk_osc_bufg			(clk				),
		.i_arst_n				(arst_n				),
		.i_spi_clk				(spi_clk			),
		.i_spi_cs_n				(spi_cs_n			),
		.i_spi_mosi				(spi_mosi			),
		.o_spi_miso_data		(miso				),
		.o_spi_miso_data_en		(miso_en			),
		.i_fval					(fval				),
		.i_sensor_reset_done	(sensor_reset_done	),
		.i_ddr_init_done		(ddr_init_done		),
		.i_ddr_error			(ddr_error			),
		.o_stream_enable		(stream_enable		),
		.o_acquisition_start	(acquisition_start	),
		.o_trigger_mode			(trigger_mode		),
		.o_reset_sensor			(reset_sensor		),
		.o_trigger_soft			(trigger_soft		),
		.o_trigger_source		(trigger_source		),
		.o_trigger_delay		(trigger_delay		),
		.o_led_ctrl				(led_ctrl			),
		.o_pixel_format			(pixel_format		)
	);

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic step_clocks(input int n);
		repeat (n) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic [15:0] field_mask(input int wd);
		return 16'((32'd1 << wd) - 32'd1);
	endfunction

	task automatic check_data16(input string name, input logic [15:0] exp, input logic [15:0] got);
		if (got !== exp) begin
			errors++;
			$display("ERR %s exp=%h got=%h", name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			errors++;
			$display("ERR %s exp=%h got=%h", name, exp, got);
		end
	endtask

	task automatic check_op(input string name, input op_e exp, input op_e got);
		if (got !== exp) begin
			errors++;
			$display("ERR %s exp=%h got=%h", name, exp, got);
		end
	endtask

	task automatic check_outputs_match_model();
		check_bit("o_stream_enable", exp_ctrl[CTRL_STREAM_EN], stream_enable);
		check_bit("o_acquisition_start", exp_ctrl[CTRL_ACQ_START], acquisition_start);
		check_bit("o_trigger_mode", exp_ctrl[CTRL_TRIG_MODE], trigger_mode);
		check_bit("o_reset_sensor", exp_ctrl[CTRL_SENSOR_RST], reset_sensor);
		check_data16("o_trigger_source", exp_trig_src, 16'(trigger_source));
		check_data16("o_trigger_delay", exp_trig_delay, trigger_delay);
		check_data16("o_led_ctrl", exp_led, 16'(led_ctrl));
		check_data16("o_pixel_format", exp_pixel_fmt, pixel_format);
	endtask

	// ------------------------------------------------------------------
	// spi master, mode 0, msb first
	// ------------------------------------------------------------------
	task automatic spi_frame(input logic [31:0] tx, input int n_bits, output logic [31:0] rx);
		rx = '0;
		miso_en_bits = '0;
		spi_cs_n = 1'b0;
		step_clocks(HALF);
		for (int i = 0; i < n_bits; i++) begin
			spi_mosi = tx[31-i];
			step_clocks(HALF);
			rx = {rx[30:0], miso};
			miso_en_bits = {miso_en_bits[30:0], miso_en};
			spi_clk = 1'b1;
			step_clocks(HALF);
			spi_clk = 1'b0;
		end
		step_clocks(HALF);
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		step_clocks(2 * HALF);
		frames_done++;
	endtask

	task automatic spi_write(input logic [7:0] addr, input logic [15:0] data);
		logic [31:0] rx;
		miso_quiet = 1'b1;
		spi_frame({OP_WRITE, addr, data}, 32, rx);
		miso_quiet = 1'b0;
	endtask

	task automatic spi_read(input logic [7:0] addr, output logic [15:0] data);
		logic [31:0] rx;
		spi_frame({OP_READ, addr, 16'h0000}, 32, rx);
		data = rx[15:0];
		// miso driven for every data bit of a read
		check_data16("o_spi_miso_data_en", 16'hffff, miso_en_bits[15:0]);
	endtask

	task automatic write_and_readback(input logic [7:0] addr, input string name,
		input logic [15:0] mask, output logic [15:0] exp);
		logic [15:0] wr;
		logic [15:0] rd;
		wr = rand_bits(16);
		exp = wr & mask;
		spi_write(addr, wr);
		spi_read(addr, rd);
		check_data16(name, exp, rd);
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_reset_values();
		logic [15:0] rd;
		exp_ctrl       = '0;
		exp_trig_src   = '0;
		exp_trig_delay = '0;
		exp_led        = '0;
		exp_pixel_fmt  = PIXEL_FMT_INIT;
		check_bit("o_spi_miso_data_en", 1'b0, miso_en);
		check_bit("o_trigger_soft", 1'b0, trigger_soft);
		check_outputs_match_model();
		spi_read(ADDR_VERSION, rd);
		check_data16("rd_version", VERSION_VALUE, rd);
	endtask

	task automatic test_write_read();
		write_and_readback(ADDR_TRIG_DELAY, "rd_trig_delay", 16'hffff, exp_trig_delay);
		check_op("latched_opcode", OP_READ, ctrl_channel_inst.ctrl_fsm_inst.opcode);
		write_and_readback(ADDR_PIXEL_FMT, "rd_pixel_fmt", 16'hffff, exp_pixel_fmt);
		write_and_readback(ADDR_LED, "rd_led", field_mask(LED_WD), exp_led);
		write_and_readback(ADDR_TRIG_SRC, "rd_trig_src", field_mask(TRIG_SRC_WD), exp_trig_src);
		check_outputs_match_model();
	endtask

	task automatic test_ctrl_bits();
		int p;
		logic [15:0] wr;
		logic [15:0] rd;
		for (p = 0; p < 16; p++) begin
			// random upper bits must not reach the outputs
			wr = rand_bits(12);
			wr = {wr[11:0], 4'(p)};
			exp_ctrl = 4'(p);
			spi_write(ADDR_CTRL, wr);
			check_op("latched_opcode", OP_WRITE, ctrl_channel_inst.ctrl_fsm_inst.opcode);
			check_outputs_match_model();
			spi_read(ADDR_CTRL, rd);
			check_data16("rd_ctrl", 16'(exp_ctrl), rd);
		end
	endtask

	task automatic test_soft_trigger();
		int base;
		int i;
		base = trig_count;
		for (i = 0; i < 3; i++) begin
			spi_write(ADDR_TRIG_SOFT, rand_bits(16));
			check_data16("trig_pulses", 16'(base + i + 1), 16'(trig_count));
			check_bit("o_trigger_soft", 1'b0, trigger_soft);
			check_outputs_match_model();
		end
	endtask

	task automatic test_status_read();
		int i;
		logic [15:0] v;
		logic [15:0] exp;
		logic [15:0] rd;
		for (i = 0; i < 4; i++) begin
			v = rand_bits(4);
			fval              = v[0];
			ddr_error         = v[1];
			ddr_init_done     = v[2];
			sensor_reset_done = v[3];
			exp = '0;
			exp[STAT_FVAL]            = fval;
			exp[STAT_DDR_ERROR]       = ddr_error;
			exp[STAT_DDR_INIT_DONE]   = ddr_init_done;
			exp[STAT_SENSOR_RST_DONE] = sensor_reset_done;
			step_clocks(4);
			spi_read(ADDR_STATUS, rd);
			check_data16("rd_status", exp, rd);
		end
	endtask

	task automatic test_robustness();
		logic [31:0] rx;
		logic [15:0] rd;
		int base;
		base = trig_count;
		miso_quiet = 1'b1;
		spi_frame({UNKNOWN_OP, ADDR_TRIG_DELAY, ~exp_trig_delay}, 32, rx);
		miso_quiet = 1'b0;
		check_outputs_match_model();
		spi_write(UNMAPPED_ADDR, rand_bits(16));
		check_outputs_match_model();
		spi_read(UNMAPPED_ADDR, rd);
		check_data16("rd_unmapped", 16'h0000, rd);
		// chip select rises after 12 of the 16 data bits
		miso_quiet = 1'b1;
		spi_frame({OP_WRITE, ADDR_PIXEL_FMT, ~exp_pixel_fmt}, 28, rx);
		miso_quiet = 1'b0;
		check_outputs_match_model();
		check_data16("trig_pulses", 16'(base), 16'(trig_count));
	endtask

	// ------------------------------------------------------------------
	// monitors and timeout
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		if (arst_n && trigger_soft) begin
			trig_count = trig_count + 1;
		end
		if (miso_quiet) begin
			check_bit("o_spi_miso_data_en", 1'b0, miso_en);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		spi_clk           = 1'b0;
		spi_cs_n          = 1'b1;
		spi_mosi          = 1'b0;
		fval              = 1'b0;
		sensor_reset_done = 1'b0;
		ddr_init_done     = 1'b0;
		ddr_error         = 1'b0;
		@(posedge arst_n);
		step_clocks(2);
		test_reset_values();
		test_write_read();
		test_ctrl_bits();
		test_soft_trigger();
		test_status_read();
		test_robustness();
		errors = errors + ctrl_channel_inst.ctrl_channel_properties_inst.assert_fails;
		$display("%0d errors after %0d frames", errors, frames_done);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
